// File: Bender.yml
package:
  name: rs_project

sources:
  # Packages first, then interfaces, then the design
  - rtl/rs_config_pkg.sv
  - rtl/rs_types_pkg.sv
  - rtl/rs_dispatch_if.sv
  - rtl/rs_issue_if.sv
  - rtl/rs_dispatch.sv
  - rtl/rs_one_entry.sv
  - rtl/rs_issue_select.sv
  - rtl/reservation_station.sv
  - target: test
    files:
      - testbench/reservation_station_tb.sv

// File: rs_project.f
rtl/rs_config_pkg.sv
rtl/rs_types_pkg.sv
rtl/rs_dispatch_if.sv
rtl/rs_issue_if.sv
rtl/rs_dispatch.sv
rtl/rs_one_entry.sv
rtl/rs_issue_select.sv
rtl/reservation_station.sv
testbench/reservation_station_tb.sv

// File: rtl/reservation_station.sv
/*
 * Reservation station top
 * Packs the dispatch and CDB ports, builds the entry array and
 * connects dispatch, entries and issue select
 */

`timescale 1ns/100ps

module reservation_station
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              dispatch_valid,
	input  logic [rs_config_pkg::DATA_W-1:0]  dispatch_opa,
	input  logic [rs_config_pkg::DATA_W-1:0]  dispatch_opb,
	input  logic                              dispatch_opa_valid,
	input  logic                              dispatch_opb_valid,
	input  logic [rs_config_pkg::TAG_W-1:0]   dispatch_dest_tag,
	input  logic [rs_config_pkg::ROB_W-1:0]   dispatch_rob_idx,
	input  rs_types_pkg::alu_func_t           dispatch_alu_func,
	input  rs_types_pkg::fu_select_t          dispatch_fu_select,
	output logic                              dispatch_ready,
	input  logic                              cdb1_valid,
	input  logic [rs_config_pkg::TAG_W-1:0]   cdb1_tag,
	input  logic [rs_config_pkg::DATA_W-1:0]  cdb1_data,
	input  logic                              cdb2_valid,
	input  logic [rs_config_pkg::TAG_W-1:0]   cdb2_tag,
	input  logic [rs_config_pkg::DATA_W-1:0]  cdb2_data,
	input  logic                              add_available,
	input  logic                              mult_available,
	output logic                              add_issue_valid,
	output logic [rs_config_pkg::DATA_W-1:0]  add_opa,
	output logic [rs_config_pkg::DATA_W-1:0]  add_opb,
	output rs_types_pkg::alu_func_t           add_func,
	output logic [rs_config_pkg::TAG_W-1:0]   add_dest_tag,
	output logic [rs_config_pkg::ROB_W-1:0]   add_rob_idx,
	output logic                              mult_issue_valid,
	output logic [rs_config_pkg::DATA_W-1:0]  mult_opa,
	output logic [rs_config_pkg::DATA_W-1:0]  mult_opb,
	output rs_types_pkg::alu_func_t           mult_func,
	output logic [rs_config_pkg::TAG_W-1:0]   mult_dest_tag,
	output logic [rs_config_pkg::ROB_W-1:0]   mult_rob_idx
);

	import rs_config_pkg::*;
	import rs_types_pkg::*;

	rs_inst_t dispatch_inst;	// Packed dispatch fields
	cdb_t     cdb1;
	cdb_t     cdb2;

	assign dispatch_inst = '{opa: dispatch_opa, opb: dispatch_opb,
		opa_valid: dispatch_opa_valid, opb_valid: dispatch_opb_valid,
		dest_tag: dispatch_dest_tag, rob_idx: dispatch_rob_idx,
		alu_func: dispatch_alu_func, fu_select: dispatch_fu_select};
	assign cdb1 = '{valid: cdb1_valid, tag: cdb1_tag, data: cdb1_data};
	assign cdb2 = '{valid: cdb2_valid, tag: cdb2_tag, data: cdb2_data};

	rs_dispatch_if disp_bus [RS_SIZE] ();	// One link per entry
	rs_issue_if    iss_bus  [RS_SIZE] ();

	////////////////////////////////////////////////////////////
	// Dispatch, entries, select
	////////////////////////////////////////////////////////////
	rs_dispatch u_dispatch (.clock, .reset, .dispatch_valid, .dispatch_inst,
		.dispatch_ready, .entries(disp_bus));

	for (genvar i = 0; i < RS_SIZE; i++)
	begin : g_entry
		rs_one_entry u_entry (.clock, .reset, .cdb1, .cdb2, .add_available,
			.mult_available, .disp(disp_bus[i]), .iss(iss_bus[i]));
	end

	rs_issue_select u_select (.iss(iss_bus),
		.add_issue_valid, .add_opa, .add_opb, .add_func, .add_dest_tag, .add_rob_idx,
		.mult_issue_valid, .mult_opa, .mult_opb, .mult_func, .mult_dest_tag,
		.mult_rob_idx);

endmodule

// File: rtl/rs_config_pkg.sv
/*
 * Reservation station sizing
 * Entry count, register file and ROB depths, and the widths derived from them
 */

package rs_config_pkg;

	////////////////////////////////////////////////////////////
	// Base sizes
	////////////////////////////////////////////////////////////
	localparam int RS_SIZE  = 4;	// Entries in the station
	localparam int PRF_SIZE = 64;	// Physical registers
	localparam int ROB_SIZE = 32;	// ROB entries
	localparam int DATA_W   = 64;	// Operand width

	////////////////////////////////////////////////////////////
	// Derived widths
	////////////////////////////////////////////////////////////
	localparam int TAG_W    = $clog2(PRF_SIZE);	// Physical register tag
	localparam int ROB_W    = $clog2(ROB_SIZE);	// ROB index
	localparam int RS_IDX_W = $clog2(RS_SIZE);	// Entry index

endpackage

// File: rtl/rs_dispatch.sv
/*
 * Dispatch side of the reservation station
 * Picks the lowest free entry and strobes the incoming instruction into it
 */

`timescale 1ns/100ps

module rs_dispatch
(
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    dispatch_valid,	// Producer offers an instruction
	input  rs_types_pkg::rs_inst_t  dispatch_inst,
	output logic                    dispatch_ready,	// Some entry is free
	rs_dispatch_if.dispatch         entries [rs_config_pkg::RS_SIZE]
);

	import rs_config_pkg::*;

	logic [RS_SIZE-1:0]  avail;		// Free bits gathered from entries
	logic [RS_SIZE-1:0]  load_vec;		// One-hot load strobes
	logic [RS_IDX_W-1:0] free_idx;		// Lowest free entry
	logic                found;		// free_idx is meaningful

	////////////////////////////////////////////////////////////
	// Entry fan-out
	////////////////////////////////////////////////////////////
	for (genvar i = 0; i < RS_SIZE; i++)
	begin : g_link
		assign avail[i]         = entries[i].available;
		assign entries[i].load  = load_vec[i];
		assign entries[i].inst  = dispatch_inst;	// Shared by all entries
	end

	////////////////////////////////////////////////////////////
	// Lowest free entry
	////////////////////////////////////////////////////////////
	always_comb
	begin
		found    = 1'b0;
		free_idx = '0;
		for (int i = RS_SIZE - 1; i >= 0; i--)	// Walk down so lowest index wins
		begin
			if (avail[i])
			begin
				found    = 1'b1;
				free_idx = RS_IDX_W'(i);
			end
		end
	end

	always_comb
	begin
		load_vec = '0;
		if (dispatch_valid && found)
			load_vec[free_idx] = 1'b1;	// Accept on this edge
	end

	assign dispatch_ready = |avail;		// Stays high until every entry is taken

	// A loaded entry reports busy on the following cycle
	a_load_taken: assert property (@(posedge clock) disable iff (reset)
		(load_vec != '0) |=> ((avail & $past(load_vec)) == '0));

endmodule

// File: rtl/rs_dispatch_if.sv
/*
 * Dispatch link into one entry
 * Load strobe and instruction in, free indication back
 */

`timescale 1ns/100ps

interface rs_dispatch_if;

	logic                    load;		// Capture inst on this edge
	rs_types_pkg::rs_inst_t  inst;		// Incoming instruction
	logic                    available;	// Entry is free

	modport dispatch (output load, output inst, input available);
	modport entry (input load, input inst, output available);

endinterface

// File: rtl/rs_issue_if.sv
/*
 * Issue link from one entry
 * Entry contents and readiness out, use-enable back from the selector
 */

`timescale 1ns/100ps

interface rs_issue_if;

	logic                      ready;		// Operands valid and unit free
	rs_types_pkg::fu_select_t  fu_select;	// Stored unit class
	rs_types_pkg::rs_inst_t    inst;		// Stored operands and tags
	logic                      use_enable;	// Issued this cycle

	modport entry
	(
		output ready,
		output fu_select,
		output inst,
		input  use_enable
	);

	modport select
	(
		input  ready,
		input  fu_select,
		input  inst,
		output use_enable
	);

endinterface

// File: rtl/rs_issue_select.sv
/*
 * Issue select
 * Grants the lowest ready entry of each unit class and muxes it to its port
 */

`timescale 1ns/100ps

module rs_issue_select
(
	rs_issue_if.select                        iss [rs_config_pkg::RS_SIZE],
	output logic                              add_issue_valid,
	output logic [rs_config_pkg::DATA_W-1:0]  add_opa,
	output logic [rs_config_pkg::DATA_W-1:0]  add_opb,
	output rs_types_pkg::alu_func_t           add_func,
	output logic [rs_config_pkg::TAG_W-1:0]   add_dest_tag,
	output logic [rs_config_pkg::ROB_W-1:0]   add_rob_idx,
	output logic                              mult_issue_valid,
	output logic [rs_config_pkg::DATA_W-1:0]  mult_opa,
	output logic [rs_config_pkg::DATA_W-1:0]  mult_opb,
	output rs_types_pkg::alu_func_t           mult_func,
	output logic [rs_config_pkg::TAG_W-1:0]   mult_dest_tag,
	output logic [rs_config_pkg::ROB_W-1:0]   mult_rob_idx
);

	import rs_config_pkg::*;
	import rs_types_pkg::*;

	logic [RS_SIZE-1:0] add_req;		// Ready adder entries
	logic [RS_SIZE-1:0] mult_req;		// Ready multiplier entries
	logic [RS_SIZE-1:0] add_grant;		// One-hot or empty
	logic [RS_SIZE-1:0] mult_grant;
	rs_inst_t           insts [RS_SIZE];	// Entry contents
	rs_inst_t           add_sel;		// Granted instruction or zero
	rs_inst_t           mult_sel;

	// Keep only the lowest set bit
	function automatic logic [RS_SIZE-1:0] lowest(input logic [RS_SIZE-1:0] req);
		return req & (~req + 1'b1);
	endfunction

	// OR mux of a one-hot grant that gives zero without a grant
	function automatic rs_inst_t pick
	(
		input logic [RS_SIZE-1:0] grant,
		input rs_inst_t           src [RS_SIZE]
	);
		rs_inst_t sel;

		sel = '0;
		for (int i = 0; i < RS_SIZE; i++)
			if (grant[i])
				sel = sel | src[i];
		return sel;
	endfunction

	////////////////////////////////////////////////////////////
	// Requests and grants
	////////////////////////////////////////////////////////////
	for (genvar i = 0; i < RS_SIZE; i++)
	begin : g_req
		assign add_req[i]        = iss[i].ready && (iss[i].fu_select == FU_ADDER);
		assign mult_req[i]       = iss[i].ready && (iss[i].fu_select == FU_MULT);
		assign insts[i]          = iss[i].inst;
		assign iss[i].use_enable = add_grant[i] | mult_grant[i];	// Frees the entry
	end

	assign add_grant  = lowest(add_req);
	assign mult_grant = lowest(mult_req);
	assign add_sel    = pick(add_grant, insts);
	assign mult_sel   = pick(mult_grant, insts);

	////////////////////////////////////////////////////////////
	// Issue ports
	////////////////////////////////////////////////////////////
	assign add_issue_valid  = |add_grant;
	assign add_opa          = add_sel.opa;
	assign add_opb          = add_sel.opb;
	assign add_func         = add_sel.alu_func;
	assign add_dest_tag     = add_sel.dest_tag;
	assign add_rob_idx      = add_sel.rob_idx;

	assign mult_issue_valid = |mult_grant;
	assign mult_opa         = mult_sel.opa;
	assign mult_opb         = mult_sel.opb;
	assign mult_func        = mult_sel.alu_func;
	assign mult_dest_tag    = mult_sel.dest_tag;
	assign mult_rob_idx     = mult_sel.rob_idx;

endmodule

// File: rtl/rs_one_entry.sv
/*
 * One reservation station entry
 * Holds a renamed instruction, snoops both CDBs for missing operands,
 * reports readiness for its unit class and frees itself when issued
 */

`timescale 1ns/100ps

module rs_one_entry
(
	input  logic                 clock,
	input  logic                 reset,
	input  rs_types_pkg::cdb_t   cdb1,		// Result broadcast one
	input  rs_types_pkg::cdb_t   cdb2,		// Result broadcast two
	input  logic                 add_available,	// An adder can accept
	input  logic                 mult_available,	// A multiplier can accept
	rs_dispatch_if.entry         disp,
	rs_issue_if.entry            iss
);

	import rs_config_pkg::*;
	import rs_types_pkg::*;

	logic            in_use;		// Entry holds a live instruction
	rs_inst_t        held;		// Stored instruction
	rs_inst_t        src;		// Incoming or held, whichever is current
	logic            active;		// Snoop the CDBs this cycle
	logic            fu_ready;		// Stored class has a free unit
	logic [DATA_W:0] next_a;		// {valid, value} after wakeup
	logic [DATA_W:0] next_b;

	// Operand wakeup against both CDBs, cdb2 has priority
	function automatic logic [DATA_W:0] wake_op
	(
		input logic [DATA_W-1:0] op,
		input logic              op_valid,
		input cdb_t              c1,
		input cdb_t              c2
	);
		logic [TAG_W-1:0] wait_tag;

		wait_tag = op[TAG_W-1:0];	// Awaited tag in the low bits
		if (op_valid)
			return {1'b1, op};
		if (c2.valid && c2.tag == wait_tag)
			return {1'b1, c2.data};
		if (c1.valid && c1.tag == wait_tag)
			return {1'b1, c1.data};
		return {1'b0, op};
	endfunction

	////////////////////////////////////////////////////////////
	// Wakeup path
	////////////////////////////////////////////////////////////
	assign src    = disp.load ? disp.inst : held;	// A beat on the load edge still counts
	assign active = disp.load || in_use;
	assign next_a = wake_op(src.opa, src.opa_valid, cdb1, cdb2);
	assign next_b = wake_op(src.opb, src.opb_valid, cdb1, cdb2);

	always_comb
	begin
		case (held.fu_select)
			FU_ADDER: fu_ready = add_available;
			FU_MULT:  fu_ready = mult_available;
			default:  fu_ready = 1'b0;	// No class stored
		endcase
	end

	////////////////////////////////////////////////////////////
	// Entry state
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			in_use         <= 1'b0;
			held.opa_valid <= 1'b0;
			held.opb_valid <= 1'b0;
			held.alu_func  <= ALU_NONE;
			held.fu_select <= FU_NONE;
		end
		else
		begin
			if (disp.load)
			begin
				held   <= disp.inst;	// Operands overwritten below
				in_use <= 1'b1;
			end
			else if (iss.use_enable)
				in_use <= 1'b0;		// Issued, slot is free next cycle

			if (active)
			begin
				held.opa       <= next_a[DATA_W-1:0];
				held.opa_valid <= next_a[DATA_W];
				held.opb       <= next_b[DATA_W-1:0];
				held.opb_valid <= next_b[DATA_W];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////
	assign disp.available = ~in_use;
	assign iss.ready      = in_use && held.opa_valid && held.opb_valid && fu_ready;
	assign iss.fu_select  = held.fu_select;
	assign iss.inst       = held;

	// Dispatch must only target a free entry
	a_load_free: assert property (@(posedge clock) disable iff (reset)
		disp.load |-> !in_use);

	// Selector grants only ready entries
	a_use_ready: assert property (@(posedge clock) disable iff (reset)
		iss.use_enable |-> iss.ready);

endmodule

// File: rtl/rs_types_pkg.sv
/*
 * Reservation station types
 * Unit classes, operation codes, the CDB beat and the dispatched instruction
 */

package rs_types_pkg;

	// Functional unit class of an instruction
	typedef enum logic [1:0]
	{
		FU_NONE  = 2'd0,	// Idle or unused entry
		FU_ADDER = 2'd1,
		FU_MULT  = 2'd2
	} fu_select_t;

	// Operation handed to the unit
	typedef enum logic [3:0]
	{
		ALU_NONE = 4'd0,	// Reset value
		ALU_ADD  = 4'd1,
		ALU_SUB  = 4'd2,
		ALU_AND  = 4'd3,
		ALU_OR   = 4'd4,
		ALU_MUL  = 4'd5
	} alu_func_t;

	// One beat on a common data bus
	typedef struct packed
	{
		logic                             valid;	// Beat present
		logic [rs_config_pkg::TAG_W-1:0]  tag;		// Producing physical register
		logic [rs_config_pkg::DATA_W-1:0] data;		// Result value
	} cdb_t;

	// Renamed instruction as it enters an entry
	// An operand with its valid low holds the awaited tag in its low bits
	typedef struct packed
	{
		logic [rs_config_pkg::DATA_W-1:0] opa;		// Value or awaited tag
		logic [rs_config_pkg::DATA_W-1:0] opb;
		logic                             opa_valid;	// Value present
		logic                             opb_valid;
		logic [rs_config_pkg::TAG_W-1:0]  dest_tag;	// Result register
		logic [rs_config_pkg::ROB_W-1:0]  rob_idx;	// ROB slot
		alu_func_t                        alu_func;
		fu_select_t                       fu_select;	// Target unit class
	} rs_inst_t;

endpackage

// File: testbench/reservation_station_tb.sv
/*
 * Reservation station testbench
 * Plays rename, CDB producers and functional units from a step table,
 * one row per cycle, and checks both issue ports and dispatch_ready
 */

`timescale 1ns/100ps

module reservation_station_tb;

	import rs_config_pkg::*;
	import rs_types_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_SLACK = 50;	// Cycles allowed past the table

	// One cycle of stimulus and the outputs expected during it
	typedef struct {
		logic     disp_valid;
		rs_inst_t inst;
		cdb_t     cdb1;
		cdb_t     cdb2;
		logic     add_av;
		logic     mult_av;
		logic     exp_ready;
		logic     exp_add_valid;
		rs_inst_t exp_add;		// All zero when no add issue
		logic     exp_mult_valid;
		rs_inst_t exp_mult;
	} step_t;

	logic clock = 1'b0;
	logic reset;
	logic dispatch_valid, dispatch_opa_valid, dispatch_opb_valid, dispatch_ready;
	logic [DATA_W-1:0] dispatch_opa, dispatch_opb;
	logic [TAG_W-1:0] dispatch_dest_tag;
	logic [ROB_W-1:0] dispatch_rob_idx;
	alu_func_t dispatch_alu_func;
	fu_select_t dispatch_fu_select;
	logic cdb1_valid, cdb2_valid, add_available, mult_available;
	logic [TAG_W-1:0] cdb1_tag, cdb2_tag;
	logic [DATA_W-1:0] cdb1_data, cdb2_data;
	logic add_issue_valid, mult_issue_valid;
	logic [DATA_W-1:0] add_opa, add_opb, mult_opa, mult_opb;
	alu_func_t add_func, mult_func;
	logic [TAG_W-1:0] add_dest_tag, mult_dest_tag;
	logic [ROB_W-1:0] add_rob_idx, mult_rob_idx;

	step_t steps [$];		// Stimulus and expect table
	int    seed = 32'hb2cf;
	int    cycle_count = 0;		// Cycles since reset release
	int    cur_step = 0;

	reservation_station dut_i (.*);

	always #4 clock = ~clock;	// 8 ns period

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	function automatic logic [DATA_W-1:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic rs_inst_t make_inst(input logic [DATA_W-1:0] opa, opb,
		input logic va, vb, input logic [TAG_W-1:0] dest, input logic [ROB_W-1:0] rob,
		input alu_func_t func, input fu_select_t fu);
		return '{opa: opa, opb: opb, opa_valid: va, opb_valid: vb, dest_tag: dest,
			rob_idx: rob, alu_func: func, fu_select: fu};
	endfunction

	function automatic cdb_t make_cdb(input logic [TAG_W-1:0] tag, input logic [DATA_W-1:0] data);
		return '{valid: 1'b1, tag: tag, data: data};
	endfunction

	task automatic add_step(input logic dv, input rs_inst_t inst, input cdb_t c1, c2,
		input logic add_av, mult_av, exp_ready, input logic eav, input rs_inst_t ea,
		input logic emv, input rs_inst_t em);
		steps.push_back('{dv, inst, c1, c2, add_av, mult_av, exp_ready, eav, ea, emv, em});
	endtask

	task automatic fail_run();
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
		assert (actual === expected)
		else
		begin
			$display("[ERROR] %s expected 0x%0h got 0x%0h at step %0d",
				name, expected, actual, cur_step);
			fail_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Step table
	////////////////////////////////////////////////////////////
	task automatic build_table();
		rs_inst_t a, m, b, c, e, x, f, g;
		rs_inst_t mq [4];
		logic [DATA_W-1:0] d1, d2, d3, d4;

		a = make_inst(rand64(), rand64(), 1'b1, 1'b1, 6'd5, 5'd1, ALU_ADD, FU_ADDER);
		m = make_inst(rand64(), rand64(), 1'b1, 1'b1, 6'd6, 5'd2, ALU_MUL, FU_MULT);
		b = make_inst(64'd12, rand64(), 1'b0, 1'b1, 6'd7, 5'd3, ALU_SUB, FU_ADDER);
		c = make_inst(rand64(), 64'd20, 1'b1, 1'b0, 6'd8, 5'd4, ALU_MUL, FU_MULT);
		e = make_inst(64'd30, 64'd31, 1'b0, 1'b0, 6'd9, 5'd5, ALU_AND, FU_ADDER);
		x = make_inst(rand64(), rand64(), 1'b1, 1'b1, 6'd30, 5'd20, ALU_OR, FU_ADDER);
		f = make_inst(rand64(), rand64(), 1'b1, 1'b1, 6'd40, 5'd24, ALU_OR, FU_ADDER);
		g = make_inst(rand64(), rand64(), 1'b1, 1'b1, 6'd41, 5'd25, ALU_MUL, FU_MULT);
		for (int k = 0; k < 4; k++)
			mq[k] = make_inst(rand64(), rand64(), 1'b1, 1'b1, 6'(16 + k), 5'(8 + k),
				ALU_MUL, FU_MULT);
		d1 = rand64();
		d2 = rand64();
		d3 = rand64();
		d4 = rand64();

		add_step(1'b0, '0, '0, '0, 1'b1, 1'b1, 1'b1, 1'b0, '0, 1'b0, '0);	// Quiet after reset
		add_step(1'b1, a, '0, '0, 1'b1, 1'b1, 1'b1, 1'b0, '0, 1'b0, '0);
		add_step(1'b1, m, '0, '0, 1'b1, 1'b1, 1'b1, 1'b1, a, 1'b0, '0);	// Add issues next cycle
		add_step(1'b0, '0, '0, '0, 1'b1, 1'b1, 1'b1, 1'b0, '0, 1'b1, m);
		// Wakeup from cdb1 after an unrelated beat
		add_step(1'b1, b, '0, '0, 1'b1, 1'b1, 1'b1, 1'b0, '0, 1'b0, '0);
		add_step(1'b0, '0, '0, make_cdb(6'd13, rand64()), 1'b1, 1'b1, 1'b1, 1'b0, '0, 1'b0, '0);
		add_step(1'b0, '0, make_cdb(6'd12, d1), '0, 1'b1, 1'b1, 1'b1, 1'b0, '0, 1'b0, '0);
		b.opa = d1;
		add_step(1'b0, '0, '0, '0, 1'b1, 1'b1, 1'b1, 1'b1, b, 1'b0, '0);
		// Wakeup from cdb2
		add_step(1'b1, c, '0, '0, 1'b1, 1'b1, 1'b1, 1'b0, '0, 1'b0, '0);
		add_step(1'b0, '0, '0, make_cdb(6'd20, d2), 1'b1, 1'b1, 1'b1, 1'b0, '0, 1'b0, '0);
		c.opb = d2;
		add_step(1'b0, '0, '0, '0, 1'b1, 1'b1, 1'b1, 1'b0, '0, 1'b1, c);
		// Beats on the dispatch edge wake both operands
		add_step(1'b1, e, make_cdb(6'd30, d3), make_cdb(6'd31, d4), 1'b1, 1'b1, 1'b1,
			1'b0, '0, 1'b0, '0);
		e.opa = d3;
		e.opb = d4;
		add_step(1'b0, '0, '0, '0, 1'b1, 1'b1, 1'b1, 1'b1, e, 1'b0, '0);
		// Fill the station with blocked multiplies
		for (int k = 0; k < 4; k++)
			add_step(1'b1, mq[k], '0, '0, 1'b1, 1'b0, 1'b1, 1'b0, '0, 1'b0, '0);
		add_step(1'b1, x, '0, '0, 1'b1, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0);	// Full, x ignored
		add_step(1'b0, '0, '0, '0, 1'b1, 1'b1, 1'b0, 1'b0, '0, 1'b1, mq[0]);
		for (int k = 1; k < 4; k++)
			add_step(1'b0, '0, '0, '0, 1'b1, 1'b1, 1'b1, 1'b0, '0, 1'b1, mq[k]);
		add_step(1'b0, '0, '0, '0, 1'b1, 1'b1, 1'b1, 1'b0, '0, 1'b0, '0);
		// Add held back until the multiply is ready too
		add_step(1'b1, f, '0, '0, 1'b0, 1'b1, 1'b1, 1'b0, '0, 1'b0, '0);
		add_step(1'b1, g, '0, '0, 1'b0, 1'b1, 1'b1, 1'b0, '0, 1'b0, '0);
		add_step(1'b0, '0, '0, '0, 1'b1, 1'b1, 1'b1, 1'b1, f, 1'b1, g);	// Both ports at once
		add_step(1'b0, '0, '0, '0, 1'b1, 1'b1, 1'b1, 1'b0, '0, 1'b0, '0);
	endtask

	task automatic apply_inputs(input step_t s);
		dispatch_valid     = s.disp_valid;
		dispatch_opa       = s.inst.opa;
		dispatch_opb       = s.inst.opb;
		dispatch_opa_valid = s.inst.opa_valid;
		dispatch_opb_valid = s.inst.opb_valid;
		dispatch_dest_tag  = s.inst.dest_tag;
		dispatch_rob_idx   = s.inst.rob_idx;
		dispatch_alu_func  = s.inst.alu_func;
		dispatch_fu_select = s.inst.fu_select;
		{cdb1_valid, cdb1_tag, cdb1_data} = s.cdb1;
		{cdb2_valid, cdb2_tag, cdb2_data} = s.cdb2;
		add_available      = s.add_av;
		mult_available     = s.mult_av;
	endtask

	task automatic check_outputs(input step_t s);
		check_value("dispatch_ready", s.exp_ready, dispatch_ready);
		check_value("add_issue_valid", s.exp_add_valid, add_issue_valid);
		check_value("add_opa", s.exp_add.opa, add_opa);
		check_value("add_opb", s.exp_add.opb, add_opb);
		check_value("add_func", s.exp_add.alu_func, add_func);
		check_value("add_dest_tag", s.exp_add.dest_tag, add_dest_tag);
		check_value("add_rob_idx", s.exp_add.rob_idx, add_rob_idx);
		check_value("mult_issue_valid", s.exp_mult_valid, mult_issue_valid);
		check_value("mult_opa", s.exp_mult.opa, mult_opa);
		check_value("mult_opb", s.exp_mult.opb, mult_opb);
		check_value("mult_func", s.exp_mult.alu_func, mult_func);
		check_value("mult_dest_tag", s.exp_mult.dest_tag, mult_dest_tag);
		check_value("mult_rob_idx", s.exp_mult.rob_idx, mult_rob_idx);
	endtask

	////////////////////////////////////////////////////////////
	// Run
	////////////////////////////////////////////////////////////
	always @(posedge clock)
	begin
		if (!reset)
			cycle_count <= cycle_count + 1;
		if (cycle_count > steps.size() + TIMEOUT_SLACK)
		begin
			$display("Timeout: the step table did not finish within %0d cycles", cycle_count);
			fail_run();
		end
	end

	initial
	begin
		reset = 1'b1;
		build_table();
		apply_inputs(steps[0]);		// Idle inputs during reset
		repeat (RESET_CYCLES) @(posedge clock);
		#1 reset = 1'b0;
		foreach (steps[i])
		begin
			@(posedge clock);
			#1;
			cur_step = i;
			apply_inputs(steps[i]);
			#6;			// Just before the next edge
			check_outputs(steps[i]);
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
